// File: hw/sw_defines.svh
`ifndef SW_DEFINES_SVH
`define SW_DEFINES_SVH

// switch dimensions
`define SW_NUM_PORTS 4
`define SW_NUM_BANKS 4

// word width on the write side and in the banks
`define SW_DATA_W 16

// 64 words per bank
`define SW_BANK_AW 6

// index widths
`define SW_BANK_IW 2
`define SW_PORT_IW 2

// four priority classes
`define SW_PRIO_W 2

`endif

// File: hw/sw_pkg.sv
`include "sw_defines.svh"

package sw_pkg;

    typedef logic [`SW_DATA_W-1:0] data_t;

    // buffer address, bank in the upper bits
    typedef struct packed {
        logic [`SW_BANK_IW-1:0] bank;
        logic [`SW_BANK_AW-1:0] offset;
    } addr_t;

    // header carried in the sop word
    typedef struct packed {
        logic [`SW_PORT_IW-1:0]                          dest;
        logic [`SW_PRIO_W-1:0]                           prio;
        logic [`SW_DATA_W-`SW_PORT_IW-`SW_PRIO_W-1:0]    rsvd;
    } pkt_hdr_t;

    // sop word seen as header or as a plain data word
    typedef union packed {
        pkt_hdr_t hdr;
        data_t    raw;
    } hdr_word_u;

    typedef struct packed {
        logic  vld;
        logic  eop;
        data_t data;
    } wr_beat_t;

    typedef struct packed {
        logic                   vld;
        logic [`SW_PORT_IW-1:0] dest;
        logic [`SW_PRIO_W-1:0]  prio;
    } hdr_evt_t;

    typedef struct packed {
        logic  vld;
        addr_t head;
        addr_t tail;
    } bank_done_t;

    typedef struct packed {
        logic [`SW_PORT_IW-1:0] port;
        logic [`SW_PORT_IW-1:0] dest;
        logic [`SW_PRIO_W-1:0]  prio;
        addr_t                  head;
        addr_t                  tail;
        logic                   linked;
        addr_t                  prev_tail;
    } join_rec_t;

endpackage

// File: hw/port_frontend.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module port_frontend (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_sop,
    input  logic                wr_eop,
    input  logic                wr_vld,
    input  sw_pkg::data_t       wr_data,
    output sw_pkg::hdr_evt_t    hdr,
    output sw_pkg::wr_beat_t    beat
);

    sw_pkg::hdr_word_u          word;
    logic                       hdr_vld;
    logic [`SW_PORT_IW-1:0]     hdr_dest;
    logic [`SW_PRIO_W-1:0]      hdr_prio;
    logic                       beat_vld;
    logic                       beat_eop;
    sw_pkg::data_t              beat_data;

    assign word.raw = wr_data;

    // valids are one-cycle pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_vld  <= 1'b0;
            beat_vld <= 1'b0;
        end else begin
            hdr_vld  <= wr_vld && wr_sop;
            beat_vld <= wr_vld && !wr_sop;
        end
    end

    always_ff @(posedge clk) begin
        // header word is consumed here and never stored
        if (wr_vld && wr_sop) begin
            hdr_dest <= word.hdr.dest;
            hdr_prio <= word.hdr.prio;
        end
        if (wr_vld && !wr_sop) begin
            beat_eop  <= wr_eop;
            beat_data <= word.raw;
        end
    end

    assign hdr.vld   = hdr_vld;
    assign hdr.dest  = hdr_dest;
    assign hdr.prio  = hdr_prio;

    assign beat.vld  = beat_vld;
    assign beat.eop  = beat_eop;
    assign beat.data = beat_data;

endmodule

// File: hw/sram_bank.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module sram_bank #(
    parameter logic [`SW_BANK_IW-1:0] bank_idx = '0
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  sw_pkg::wr_beat_t [`SW_NUM_PORTS-1:0]    beats,
    input  logic [`SW_PORT_IW-1:0]                  owner,
    input  logic                                    owner_vld,
    input  sw_pkg::addr_t                           rd_addr,
    output sw_pkg::data_t                           rd_data,
    output sw_pkg::bank_done_t                      done
);

    sw_pkg::data_t              mem [1 << `SW_BANK_AW];
    logic [`SW_BANK_AW-1:0]     wr_ptr;
    logic                       in_pkt;
    sw_pkg::addr_t              head_q;
    sw_pkg::wr_beat_t           sel;
    sw_pkg::addr_t              cur_addr;
    logic                       we;
    logic                       done_vld;
    sw_pkg::addr_t              done_head;
    sw_pkg::addr_t              done_tail;

    // only the owning port may write
    assign sel             = beats[owner];
    assign we              = owner_vld && sel.vld;
    assign cur_addr.bank   = bank_idx;
    assign cur_addr.offset = wr_ptr;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_ptr] <= sel.data;
        end
    end

    // pointer wraps past the bank depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            in_pkt   <= 1'b0;
            done_vld <= 1'b0;
        end else begin
            done_vld <= we && sel.eop;
            if (we) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_pkt <= !sel.eop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we && !in_pkt) begin
            head_q <= cur_addr;
        end
        // single-word packet has head equal to tail
        if (we && sel.eop) begin
            done_head <= in_pkt ? head_q : cur_addr;
            done_tail <= cur_addr;
        end
    end

    assign done.vld  = done_vld;
    assign done.head = done_head;
    assign done.tail = done_tail;

    always_ff @(posedge clk) begin
        rd_data <= (rd_addr.bank == bank_idx) ? mem[rd_addr.offset] : '0;
    end

endmodule

// File: hw/queue_table.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module queue_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`SW_PORT_IW-1:0]  dest,
    input  logic [`SW_PRIO_W-1:0]   prio,
    input  logic                    upd,
    input  sw_pkg::addr_t           upd_tail,
    output logic                    linked,
    output sw_pkg::addr_t           prev_tail
);

    localparam int num_q = 1 << (`SW_PORT_IW + `SW_PRIO_W);

    logic [num_q-1:0]                       nonempty;
    sw_pkg::addr_t                          tail_q [num_q];
    logic [`SW_PORT_IW+`SW_PRIO_W-1:0]      idx;

    // one queue per dest and prio
    assign idx       = {dest, prio};
    assign linked    = nonempty[idx];
    assign prev_tail = tail_q[idx];

    // queues never drain here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nonempty <= '0;
        end else if (upd) begin
            nonempty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd) begin
            tail_q[idx] <= upd_tail;
        end
    end

endmodule

// File: hw/switch_ctrl.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module switch_ctrl (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        match_mode,
    input  sw_pkg::hdr_evt_t [`SW_NUM_PORTS-1:0]        hdr,
    input  sw_pkg::wr_beat_t [`SW_NUM_PORTS-1:0]        beats,
    input  sw_pkg::bank_done_t [`SW_NUM_BANKS-1:0]      done,
    output logic [`SW_NUM_BANKS-1:0][`SW_PORT_IW-1:0]   owner,
    output logic [`SW_NUM_BANKS-1:0]                    owner_vld,
    output logic [`SW_PORT_IW-1:0]                      q_dest,
    output logic [`SW_PRIO_W-1:0]                       q_prio,
    output logic                                        q_upd,
    output sw_pkg::addr_t                               q_tail,
    input  logic                                        q_linked,
    input  sw_pkg::addr_t                               q_prev_tail,
    output logic                                        join_req,
    input  logic                                        join_ack,
    output sw_pkg::join_rec_t                           join_rec,
    output logic [`SW_NUM_PORTS-1:0]                    wr_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_ack
    } join_state_t;

    join_state_t                                        state;
    logic [`SW_NUM_PORTS-1:0][`SW_PORT_IW-1:0]          hdr_dest_q;
    logic [`SW_NUM_PORTS-1:0][`SW_PRIO_W-1:0]           hdr_prio_q;
    logic [`SW_NUM_PORTS-1:0]                           pend_vld;
    sw_pkg::addr_t [`SW_NUM_PORTS-1:0]                  pend_head;
    sw_pkg::addr_t [`SW_NUM_PORTS-1:0]                  pend_tail;
    logic [`SW_NUM_PORTS-1:0]                           blocked;
    logic [`SW_NUM_PORTS-1:0]                           grant_vld;
    logic [`SW_NUM_PORTS-1:0][`SW_BANK_IW-1:0]          grant_bank;
    logic [`SW_NUM_BANKS-1:0]                           taken;
    logic                                               any_pend;
    logic [`SW_PORT_IW-1:0]                             sel_port;
    logic [`SW_PORT_IW-1:0]                             cur_port;

    // bank grant, lower ports claim first
    always_comb begin
        taken      = owner_vld;
        grant_vld  = '0;
        grant_bank = '0;
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            if (hdr[p].vld) begin
                if (!match_mode) begin
                    grant_vld[p]  = 1'b1;
                    grant_bank[p] = `SW_BANK_IW'(p);
                end else begin
                    // descending scan leaves the lowest free bank
                    for (int b = `SW_NUM_BANKS - 1; b >= 0; b--) begin
                        if (!taken[b]) begin
                            grant_vld[p]  = 1'b1;
                            grant_bank[p] = `SW_BANK_IW'(b);
                        end
                    end
                end
                if (grant_vld[p]) begin
                    taken[grant_bank[p]] = 1'b1;
                end
            end
        end
    end

    // lowest pending port wins the join output
    always_comb begin
        sel_port = '0;
        for (int p = `SW_NUM_PORTS - 1; p >= 0; p--) begin
            if (pend_vld[p]) begin
                sel_port = `SW_PORT_IW'(p);
            end
        end
    end

    assign any_pend = |pend_vld;
    assign q_dest   = hdr_dest_q[sel_port];
    assign q_prio   = hdr_prio_q[sel_port];
    assign q_tail   = pend_tail[sel_port];
    assign q_upd    = (state == st_idle) && any_pend;

    // drop ready as soon as the eop beat leaves the frontend
    always_comb begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            wr_ready[p] = !blocked[p] && !(beats[p].vld && beats[p].eop);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_vld <= '0;
            pend_vld  <= '0;
            blocked   <= '0;
            join_req  <= 1'b0;
            state     <= st_idle;
        end else begin
            for (int b = 0; b < `SW_NUM_BANKS; b++) begin
                if (done[b].vld) begin
                    owner_vld[b]       <= 1'b0;
                    pend_vld[owner[b]] <= 1'b1;
                end
            end
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                if (grant_vld[p]) begin
                    owner_vld[grant_bank[p]] <= 1'b1;
                end
                if (beats[p].vld && beats[p].eop) begin
                    blocked[p] <= 1'b1;
                end
            end
            // four-phase req/ack
            case (state)
                st_idle: begin
                    if (any_pend) begin
                        join_req <= 1'b1;
                        state    <= st_req;
                    end
                end
                st_req: begin
                    if (join_ack) begin
                        join_req <= 1'b0;
                        state    <= st_ack;
                    end
                end
                st_ack: begin
                    if (!join_ack) begin
                        pend_vld[cur_port] <= 1'b0;
                        blocked[cur_port]  <= 1'b0;
                        state              <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            if (grant_vld[p]) begin
                owner[grant_bank[p]] <= `SW_PORT_IW'(p);
                hdr_dest_q[p]        <= hdr[p].dest;
                hdr_prio_q[p]        <= hdr[p].prio;
            end
        end
        for (int b = 0; b < `SW_NUM_BANKS; b++) begin
            if (done[b].vld) begin
                pend_head[owner[b]] <= done[b].head;
                pend_tail[owner[b]] <= done[b].tail;
            end
        end
        // record held stable while req is up
        if (q_upd) begin
            cur_port           <= sel_port;
            join_rec.port      <= sel_port;
            join_rec.dest      <= q_dest;
            join_rec.prio      <= q_prio;
            join_rec.head      <= pend_head[sel_port];
            join_rec.tail      <= q_tail;
            join_rec.linked    <= q_linked;
            join_rec.prev_tail <= q_prev_tail;
        end
    end

endmodule

// File: hw/pkt_switch_wr.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module pkt_switch_wr (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`SW_NUM_PORTS-1:0]                wr_sop,
    input  logic [`SW_NUM_PORTS-1:0]                wr_eop,
    input  logic [`SW_NUM_PORTS-1:0]                wr_vld,
    input  sw_pkg::data_t [`SW_NUM_PORTS-1:0]       wr_data,
    output logic [`SW_NUM_PORTS-1:0]                wr_ready,
    input  logic                                    match_mode,
    output logic                                    join_req,
    input  logic                                    join_ack,
    output sw_pkg::join_rec_t                       join_rec,
    input  sw_pkg::addr_t                           mem_rd_addr,
    output sw_pkg::data_t                           mem_rd_data
);

    sw_pkg::hdr_evt_t [`SW_NUM_PORTS-1:0]           hdr;
    sw_pkg::wr_beat_t [`SW_NUM_PORTS-1:0]           beats;
    sw_pkg::bank_done_t [`SW_NUM_BANKS-1:0]         done;
    logic [`SW_NUM_BANKS-1:0][`SW_PORT_IW-1:0]      owner;
    logic [`SW_NUM_BANKS-1:0]                       owner_vld;
    sw_pkg::data_t [`SW_NUM_BANKS-1:0]              bank_rd_data;
    logic [`SW_PORT_IW-1:0]                         q_dest;
    logic [`SW_PRIO_W-1:0]                          q_prio;
    logic                                           q_upd;
    sw_pkg::addr_t                                  q_tail;
    logic                                           q_linked;
    sw_pkg::addr_t                                  q_prev_tail;

    genvar p;
    generate
        for (p = 0; p < `SW_NUM_PORTS; p++) begin : g_port
            port_frontend u_port_frontend (
                .clk     (clk),
                .rst_n   (rst_n),
                .wr_sop  (wr_sop[p]),
                .wr_eop  (wr_eop[p]),
                .wr_vld  (wr_vld[p]),
                .wr_data (wr_data[p]),
                .hdr     (hdr[p]),
                .beat    (beats[p])
            );
        end
    endgenerate

    genvar b;
    generate
        for (b = 0; b < `SW_NUM_BANKS; b++) begin : g_bank
            localparam logic [`SW_BANK_IW-1:0] this_bank = b;

            sram_bank #(
                .bank_idx (this_bank)
            ) u_sram_bank (
                .clk       (clk),
                .rst_n     (rst_n),
                .beats     (beats),
                .owner     (owner[b]),
                .owner_vld (owner_vld[b]),
                .rd_addr   (mem_rd_addr),
                .rd_data   (bank_rd_data[b]),
                .done      (done[b])
            );
        end
    endgenerate

    // non-addressed banks return zero
    always_comb begin
        mem_rd_data = '0;
        for (int i = 0; i < `SW_NUM_BANKS; i++) begin
            mem_rd_data = mem_rd_data | bank_rd_data[i];
        end
    end

    switch_ctrl u_switch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .match_mode  (match_mode),
        .hdr         (hdr),
        .beats       (beats),
        .done        (done),
        .owner       (owner),
        .owner_vld   (owner_vld),
        .q_dest      (q_dest),
        .q_prio      (q_prio),
        .q_upd       (q_upd),
        .q_tail      (q_tail),
        .q_linked    (q_linked),
        .q_prev_tail (q_prev_tail),
        .join_req    (join_req),
        .join_ack    (join_ack),
        .join_rec    (join_rec),
        .wr_ready    (wr_ready)
    );

    queue_table u_queue_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .dest      (q_dest),
        .prio      (q_prio),
        .upd       (q_upd),
        .upd_tail  (q_tail),
        .linked    (q_linked),
        .prev_tail (q_prev_tail)
    );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam time half_period = 5ns;
    localparam int  reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release reset away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: testbench/tb_pkt_switch_wr.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module tb_pkt_switch_wr;

    localparam int num_tests      = 6;
    localparam int cycles_per_test = 300;
    localparam int timeout_cycles = num_tests * cycles_per_test;
    localparam int num_q          = 1 << (`SW_PORT_IW + `SW_PRIO_W);

    logic                                   clk;
    logic                                   rst_n;
    logic [`SW_NUM_PORTS-1:0]               wr_sop;
    logic [`SW_NUM_PORTS-1:0]               wr_eop;
    logic [`SW_NUM_PORTS-1:0]               wr_vld;
    sw_pkg::data_t [`SW_NUM_PORTS-1:0]      wr_data;
    logic [`SW_NUM_PORTS-1:0]               wr_ready;
    logic                                   match_mode;
    logic                                   join_req;
    logic                                   join_ack;
    sw_pkg::join_rec_t                      join_rec;
    sw_pkg::addr_t                          mem_rd_addr;
    sw_pkg::data_t                          mem_rd_data;

    int                                     err_cnt;
    int                                     cycle_cnt;
    logic [31:0]                            lcg_state;

    // per-port packet setup and what was sent
    logic [`SW_PORT_IW-1:0]                 pkt_dest [`SW_NUM_PORTS];
    logic [`SW_PRIO_W-1:0]                  pkt_prio [`SW_NUM_PORTS];
    logic [`SW_BANK_IW-1:0]                 pkt_bank [`SW_NUM_PORTS];
    int                                     pkt_len  [`SW_NUM_PORTS];
    int                                     head_off [`SW_NUM_PORTS];
    sw_pkg::data_t                          sent     [`SW_NUM_PORTS][64];

    // reference model of buffer and queues
    int                                     ref_wptr [`SW_NUM_BANKS];
    logic                                   ref_nonempty [num_q];
    sw_pkg::addr_t                          ref_tail [num_q];

    tb_clkgen u_tb_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pkt_switch_wr u_pkt_switch_wr (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .wr_ready    (wr_ready),
        .match_mode  (match_mode),
        .join_req    (join_req),
        .join_ack    (join_ack),
        .join_rec    (join_rec),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data)
    );

    function automatic sw_pkg::data_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return sw_pkg::data_t'(lcg_state >> 15);
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_rec(input string name, input sw_pkg::join_rec_t got,
                             input sw_pkg::join_rec_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input sw_pkg::data_t got,
                              input sw_pkg::data_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ready(input string name, input logic [`SW_NUM_PORTS-1:0] got,
                               input logic [`SW_NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic setup_pkt(input int port, input int dest, input int prio, input int bank);
        pkt_dest[port] = `SW_PORT_IW'(dest);
        pkt_prio[port] = `SW_PRIO_W'(prio);
        pkt_bank[port] = `SW_BANK_IW'(bank);
    endtask

    // all ports in mask send in lock step
    task automatic send_pkts(input logic [`SW_NUM_PORTS-1:0] mask, input int len);
        sw_pkg::pkt_hdr_t h;
        @(negedge clk);
        while ((wr_ready & mask) != mask) begin
            @(negedge clk);
        end
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            if (mask[p]) begin
                h.dest         = pkt_dest[p];
                h.prio         = pkt_prio[p];
                h.rsvd         = '0;
                wr_data[p]     = h;
                wr_sop[p]      = 1'b1;
                wr_vld[p]      = 1'b1;
                pkt_len[p]     = len;
                head_off[p]    = ref_wptr[pkt_bank[p]];
                ref_wptr[pkt_bank[p]] += len;
            end
        end
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                if (mask[p]) begin
                    wr_sop[p]  = 1'b0;
                    wr_eop[p]  = (i == len - 1);
                    wr_data[p] = lcg_next();
                    sent[p][i] = wr_data[p];
                end
            end
        end
        @(negedge clk);
        wr_vld = wr_vld & ~mask;
        wr_eop = wr_eop & ~mask;
    endtask

    // answers one join_req, ready bits in hold_low must stay low meanwhile
    task automatic serve_join(input int ack_delay, input logic [`SW_NUM_PORTS-1:0] hold_low,
                              output sw_pkg::join_rec_t rec);
        bit req_dropped;
        bit rec_changed;
        bit ready_seen;
        req_dropped = 0;
        rec_changed = 0;
        ready_seen  = 0;
        @(negedge clk);
        while (!join_req) begin
            @(negedge clk);
        end
        rec = join_rec;
        for (int i = 0; i < ack_delay; i++) begin
            @(negedge clk);
            req_dropped |= !join_req;
            rec_changed |= (join_rec !== rec);
            ready_seen  |= |(wr_ready & hold_low);
        end
        join_ack = 1'b1;
        @(negedge clk);
        while (join_req) begin
            @(negedge clk);
        end
        join_ack = 1'b0;
        if (req_dropped) report_error("join_req dropped while ack was withheld");
        if (rec_changed) report_error("join_rec changed while ack was withheld");
        if (ready_seen) report_error("wr_ready rose while its record was pending");
    endtask

    task automatic expect_join(input int port, input int ack_delay,
                               input logic [`SW_NUM_PORTS-1:0] hold_low);
        sw_pkg::join_rec_t got;
        sw_pkg::join_rec_t exp;
        int                q;
        serve_join(ack_delay, hold_low, got);
        q               = {pkt_dest[port], pkt_prio[port]};
        exp.port        = `SW_PORT_IW'(port);
        exp.dest        = pkt_dest[port];
        exp.prio        = pkt_prio[port];
        exp.head.bank   = pkt_bank[port];
        exp.head.offset = `SW_BANK_AW'(head_off[port]);
        exp.tail.bank   = pkt_bank[port];
        exp.tail.offset = `SW_BANK_AW'(head_off[port] + pkt_len[port] - 1);
        exp.linked      = ref_nonempty[q];
        exp.prev_tail   = ref_tail[q];
        // prev_tail means nothing for an empty queue
        if (!exp.linked) begin
            got.prev_tail = '0;
            exp.prev_tail = '0;
        end
        check_rec("join_rec", got, exp);
        ref_nonempty[q] = 1'b1;
        ref_tail[q]     = exp.tail;
    endtask

    task automatic check_readback(input int port);
        for (int i = 0; i < pkt_len[port]; i++) begin
            mem_rd_addr.bank   = pkt_bank[port];
            mem_rd_addr.offset = `SW_BANK_AW'(head_off[port] + i);
            @(negedge clk);
            check_word("mem_rd_data", mem_rd_data, sent[port][i]);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("join_req", join_req, 1'b0);
        check_ready("wr_ready", wr_ready, '1);
    endtask

    task automatic test_single_packet();
        match_mode = 1'b0;
        setup_pkt(1, 2, 1, 1);
        send_pkts(4'b0010, 5);
        expect_join(1, 2, 4'b0010);
        check_readback(1);
    endtask

    task automatic test_queue_linking();
        setup_pkt(2, 2, 1, 2);
        send_pkts(4'b0100, 3);
        expect_join(2, 1, 4'b0100);
        check_readback(2);
    endtask

    task automatic test_prio_split();
        setup_pkt(0, 2, 3, 0);
        send_pkts(4'b0001, 4);
        expect_join(0, 0, 4'b0001);
    endtask

    // lowest free bank, lower ports first
    task automatic test_mode1_alloc();
        @(negedge clk);
        match_mode = 1'b1;
        setup_pkt(3, 1, 0, 0);
        send_pkts(4'b1000, 4);
        expect_join(3, 1, 4'b1000);
        check_readback(3);
        setup_pkt(0, 3, 2, 0);
        setup_pkt(2, 3, 2, 1);
        send_pkts(4'b0101, 6);
        expect_join(0, 1, 4'b0101);
        expect_join(2, 1, 4'b0100);
        check_readback(0);
        check_readback(2);
    endtask

    task automatic test_order_backpressure();
        @(negedge clk);
        match_mode = 1'b0;
        setup_pkt(0, 0, 0, 0);
        setup_pkt(3, 0, 0, 3);
        send_pkts(4'b1001, 3);
        expect_join(0, 20, 4'b1001);
        @(negedge clk);
        check_ready("wr_ready", wr_ready & 4'b1001, 4'b0001);
        expect_join(3, 2, 4'b1000);
        @(negedge clk);
        check_ready("wr_ready", wr_ready, '1);
    endtask

    initial begin
        wr_sop      = '0;
        wr_eop      = '0;
        wr_vld      = '0;
        wr_data     = '0;
        match_mode  = 1'b0;
        join_ack    = 1'b0;
        mem_rd_addr = '0;
        err_cnt     = 0;
        lcg_state   = 32'd72867;
        for (int b = 0; b < `SW_NUM_BANKS; b++) begin
            ref_wptr[b] = 0;
        end
        for (int q = 0; q < num_q; q++) begin
            ref_nonempty[q] = 1'b0;
            ref_tail[q]     = '0;
        end
        wait (rst_n === 1'b1);
        test_reset_state();
        test_single_packet();
        test_queue_linking();
        test_prio_split();
        test_mode1_alloc();
        test_order_backpressure();
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hw
hw/sw_pkg.sv
hw/port_frontend.sv
hw/sram_bank.sv
hw/queue_table.sv
hw/switch_ctrl.sv
hw/pkt_switch_wr.sv
testbench/tb_clkgen.sv
testbench/tb_pkt_switch_wr.sv

// File: Bender.yml
package:
  name: pkt_switch_wr

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sw_pkg.sv
      - hw/port_frontend.sv
      - hw/sram_bank.sv
      - hw/queue_table.sv
      - hw/switch_ctrl.sv
      - hw/pkt_switch_wr.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/tb_clkgen.sv
      - testbench/tb_pkt_switch_wr.sv
